// ==== run_sim.sh ====
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log=sim.log

verilator --binary --timing -Wno-fatal --top-module seq_soc_tb \
   -f seq_soc.f --Mdir "$build_dir" -o seq_soc_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

"./$build_dir/seq_soc_sim" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "sim failed" "$log"; then
   exit 1
fi
if ! grep -q "sim passed" "$log"; then
   echo "simulation ended without a result"
   exit 1
fi
exit 0

// ==== seq_soc.f ====
+incdir+verilog
verilog/seq_pkg.sv
verilog/seq_prog_mem.sv
verilog/seq_core.sv
verilog/cmd_buffer.sv
verilog/dev_bank.sv
verilog/seq_soc.sv
test/seq_soc_tb.sv

// ==== test/seq_soc_tb.sv ====
`timescale 1ns/1ps
`include "seq_consts.svh"

module seq_soc_tb;

   import seq_pkg::*;

   localparam int TEST_COUNT      = 6;
   localparam int CYCLES_PER_TEST = 2000;

   logic                    clock;
   logic                    reset;
   logic                    prog_wen;
   logic [`SEQ_ADDR_W-1:0]  prog_addr;
   seq_inst_t               prog_data;
   logic [7:0]              ireg [4];
   logic [`SEQ_ADDR_W-1:0]  next;
   logic                    error;
   logic [`DEV_COUNT*8-1:0] dev_values;
   logic                    idle;

   seq_inst_t              prog [$];            // program under construction
   logic [7:0]             model [`DEV_COUNT];  // expected device registers
   logic [7:0]             in_val [4];          // values the input registers will carry
   logic [`SEQ_ADDR_W-1:0] halt_addr;
   int                     errors;
   int                     tests_passed;
   int                     tests_failed;

   seq_soc seq_soc_inst (
      .clock      (clock),
      .reset      (reset),
      .prog_wen   (prog_wen),
      .prog_addr  (prog_addr),
      .prog_data  (prog_data),
      .ireg_0     (ireg[0]),
      .ireg_1     (ireg[1]),
      .ireg_2     (ireg[2]),
      .ireg_3     (ireg[3]),
      .next       (next),
      .error      (error),
      .dev_values (dev_values),
      .idle       (idle)
   );

   initial begin
      clock = 1'b0;
      forever #2 clock = ~clock;
   end

   initial begin
      repeat (TEST_COUNT * CYCLES_PER_TEST) @(posedge clock);
      $display("watchdog expired before the tests completed");
      $display("sim failed");
      $finish;
   end

   function automatic seq_inst_t cmd_inst(input logic [3:0] op, input int dev,
                                          input logic [3:0] dev_cmd, input logic [7:0] arg);
      seq_inst_t w;
      w.cmd_view.opcode  = op;
      w.cmd_view.pad     = 1'b0;
      w.cmd_view.dev     = 3'(dev);
      w.cmd_view.dev_cmd = dev_cmd;
      w.cmd_view.arg     = arg; // low two bits double as src for cr
      return w;
   endfunction

   function automatic seq_inst_t jump_inst(input logic [3:0] op, input logic [7:0] label,
                                           input logic [1:0] src);
      seq_inst_t w;
      w.jump_view.opcode = op;
      w.jump_view.label  = label;
      w.jump_view.unused = '0;
      w.jump_view.src    = src;
      return w;
   endfunction

   task automatic model_apply(input int dev, input logic [3:0] dev_cmd, input logic [7:0] arg);
      case (dev_cmd)
         `DEV_OP_LOAD:  model[dev] = arg;
         `DEV_OP_ADD:   model[dev] = model[dev] + arg;
         `DEV_OP_XOR:   model[dev] = model[dev] ^ arg;
         `DEV_OP_CLEAR: model[dev] = 8'h00;
         default:       model[dev] = model[dev]; // unknown command leaves it unchanged
      endcase
   endtask

   task automatic emit_ci(input int dev, input logic [3:0] dev_cmd, input logic [7:0] arg);
      prog.push_back(cmd_inst(`SEQ_OP_CI, dev, dev_cmd, arg));
      model_apply(dev, dev_cmd, arg);
   endtask

   task automatic emit_cr(input int dev, input logic [3:0] dev_cmd, input int src);
      prog.push_back(cmd_inst(`SEQ_OP_CR, dev, dev_cmd, 8'(src)));
      model_apply(dev, dev_cmd, in_val[src]);
   endtask

   // self jump marks the end of a program
   task automatic emit_halt();
      halt_addr = `SEQ_ADDR_W'(prog.size());
      prog.push_back(jump_inst(`SEQ_OP_JI, halt_addr, 2'd0));
   endtask

   task automatic new_test();
      prog.delete();
      errors = 0;
      for (int i = 0; i < `DEV_COUNT; i++) begin
         model[i] = 8'h00; // reset sweep clears the bank
      end
   endtask

   task automatic set_inputs(input logic [7:0] a0, input logic [7:0] a1,
                             input logic [7:0] a2, input logic [7:0] a3);
      in_val[0] = a0;
      in_val[1] = a1;
      in_val[2] = a2;
      in_val[3] = a3;
      @(posedge clock);
      for (int i = 0; i < 4; i++) begin
         ireg[i] <= in_val[i];
      end
   endtask

   // program is written only while reset is high
   task automatic load_program();
      @(posedge clock);
      reset <= 1'b1;
      foreach (prog[i]) begin
         @(posedge clock);
         prog_wen  <= 1'b1;
         prog_addr <= `SEQ_ADDR_W'(i);
         prog_data <= prog[i];
      end
      @(posedge clock);
      prog_wen <= 1'b0;
      repeat (2) @(posedge clock);
      reset <= 1'b0;
   endtask

   task automatic run_until_idle();
      int cycles;
      cycles = 0;
      while (!(next == halt_addr || error) && cycles < CYCLES_PER_TEST) begin
         @(negedge clock);
         cycles++;
      end
      repeat (2) @(negedge clock); // last command reaches the buffer
      while (!idle && cycles < CYCLES_PER_TEST) begin
         @(negedge clock);
         cycles++;
      end
      if (cycles >= CYCLES_PER_TEST) begin
         $display("program never reached its halt address and went idle");
         errors++;
      end
   endtask

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] expected);
      if (got !== expected) begin
         $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, expected);
         errors++;
      end
   endtask

   task automatic check_devices();
      for (int i = 0; i < `DEV_COUNT; i++) begin
         check($sformatf("dev_values[%0d]", i), 32'(dev_values[i*8 +: 8]), 32'(model[i]));
      end
   endtask

   task automatic end_test(input string name);
      if (errors == 0) begin
         tests_passed++;
         $display("test %s: ok", name);
      end else begin
         tests_failed++;
         $display("test %s: %0d errors", name, errors);
      end
   endtask

   task automatic test_immediate();
      new_test();
      for (int d = 0; d < `DEV_COUNT; d++) begin
         emit_ci(d, `DEV_OP_LOAD, 8'(d * 16 + 3));
         emit_ci(d, `DEV_OP_ADD, 8'(8'h55 + d));
         emit_ci(d, `DEV_OP_XOR, 8'ha5);
         if (d % 2 == 0) begin
            emit_ci(d, `DEV_OP_CLEAR, 8'h77); // argument ignored
            emit_ci(d, `DEV_OP_ADD, 8'(d + 7));
         end
      end
      emit_halt();
      load_program();
      run_until_idle();
      check("next", 32'(next), 32'(halt_addr));
      check_devices();
      end_test("immediate commands");
   endtask

   task automatic test_register();
      new_test();
      set_inputs(8'h12, 8'h34, 8'h80, 8'hff);
      for (int d = 0; d < `DEV_COUNT; d++) begin
         emit_cr(d, `DEV_OP_LOAD, d % 4);
         emit_cr(d, `DEV_OP_ADD, (d + 1) % 4); // ff wraps
         if (d >= 4) begin
            emit_cr(d, `DEV_OP_XOR, (d + 2) % 4);
         end
      end
      emit_halt();
      load_program();
      run_until_idle();
      check_devices();
      end_test("register commands");
   endtask

   task automatic test_flow();
      new_test();
      set_inputs(8'h00, 8'h05, 8'd14, 8'h00);
      emit_ci(0, `DEV_OP_LOAD, 8'h11);                            // 0
      prog.push_back(jump_inst(`SEQ_OP_JZ, 8'd3, 2'd0));          // 1 taken
      prog.push_back(cmd_inst(`SEQ_OP_CI, 1, `DEV_OP_LOAD, 8'hee));
      emit_ci(1, `DEV_OP_ADD, 8'h22);                             // 3
      prog.push_back(jump_inst(`SEQ_OP_JN, 8'd6, 2'd0));          // 4 falls through
      emit_ci(2, `DEV_OP_LOAD, 8'h33);                            // 5
      prog.push_back(jump_inst(`SEQ_OP_JN, 8'd8, 2'd1));          // 6 taken
      prog.push_back(cmd_inst(`SEQ_OP_CI, 3, `DEV_OP_LOAD, 8'hee));
      prog.push_back(jump_inst(`SEQ_OP_JZ, 8'd10, 2'd1));         // 8 falls through
      emit_ci(3, `DEV_OP_ADD, 8'h44);                             // 9
      prog.push_back(jump_inst(`SEQ_OP_JI, 8'd12, 2'd0));         // 10
      prog.push_back(cmd_inst(`SEQ_OP_CI, 4, `DEV_OP_LOAD, 8'hee));
      prog.push_back(jump_inst(`SEQ_OP_JR, 8'd0, 2'd2));          // 12 to ireg_2
      prog.push_back(cmd_inst(`SEQ_OP_CI, 5, `DEV_OP_LOAD, 8'hee));
      emit_ci(5, `DEV_OP_ADD, 8'h55);                             // 14
      emit_halt();
      load_program();
      run_until_idle();
      check("next", 32'(next), 32'(halt_addr));
      check_devices();
      end_test("control flow");
   endtask

   task automatic test_burst();
      new_test();
      for (int i = 0; i < 40; i++) begin
         emit_ci(i % 8, 4'(i % 3), 8'(i * 7 + 1)); // loads make order visible
      end
      emit_halt();
      load_program();
      run_until_idle();
      check("next", 32'(next), 32'(halt_addr));
      check_devices();
      end_test("command burst");
   endtask

   task automatic test_illegal();
      new_test();
      emit_ci(0, `DEV_OP_LOAD, 8'h3c);
      emit_ci(6, `DEV_OP_LOAD, 8'h81);
      emit_ci(0, `DEV_OP_XOR, 8'h0f);
      prog.push_back(cmd_inst(4'hf, 0, 4'h0, 8'h00));
      prog.push_back(cmd_inst(`SEQ_OP_CI, 1, `DEV_OP_LOAD, 8'hee)); // never issued
      prog.push_back(cmd_inst(`SEQ_OP_CI, 0, `DEV_OP_CLEAR, 8'h00));
      emit_halt();
      load_program();
      run_until_idle();
      check("error", 32'(error), 32'd1);
      check("next", 32'(next), 32'd0);
      check_devices();
      end_test("illegal opcode");
   endtask

   task automatic test_random();
      int         kind;
      int         dev;
      logic [3:0] dev_cmd;
      logic [7:0] arg;
      new_test();
      set_inputs(8'($urandom), 8'($urandom), 8'($urandom), 8'($urandom));
      for (int i = 0; i < 30; i++) begin
         kind    = int'($urandom_range(0, 2));
         dev     = int'($urandom_range(0, 7));
         dev_cmd = 4'($urandom_range(0, 4)); // 4 is an unknown device command
         arg     = 8'($urandom);
         case (kind)
            0:       prog.push_back(cmd_inst(`SEQ_OP_NO, 0, 4'h0, 8'h00));
            1:       emit_ci(dev, dev_cmd, arg);
            default: emit_cr(dev, dev_cmd, int'($urandom_range(0, 3)));
         endcase
      end
      emit_halt();
      load_program();
      run_until_idle();
      check("next", 32'(next), 32'(halt_addr));
      check_devices();
      end_test("random program");
   endtask

   initial begin
      reset     <= 1'b1;
      prog_wen  <= 1'b0;
      prog_addr <= '0;
      prog_data <= '0;
      for (int i = 0; i < 4; i++) begin
         ireg[i]   <= 8'h00;
         in_val[i] = 8'h00;
      end
      void'($urandom(32'hd153));
      tests_passed = 0;
      tests_failed = 0;
      repeat (2) @(posedge clock);
      test_immediate();
      test_register();
      test_flow();
      test_burst();
      test_illegal();
      test_random();
      $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
      if (tests_failed == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

// ==== verilog/cmd_buffer.sv ====
`timescale 1ns/1ps
`include "seq_consts.svh"

module cmd_buffer (
   input  logic                  clock,
   input  logic                  reset,
   input  logic [`SEQ_CMD_W-1:0] oreg,
   input  logic [`DEV_COUNT-1:0] oreg_wen,
   input  logic                  cmd_pop,
   output logic                  cmd_valid,
   output logic [2:0]            cmd_dev,
   output logic [`SEQ_CMD_W-1:0] cmd_word,
   output logic                  hold,
   output logic                  empty
);

   localparam int PTR_W   = $clog2(`CMD_DEPTH);
   localparam int ENTRY_W = `SEQ_CMD_W + 3;

   logic [ENTRY_W-1:0] fifo [`CMD_DEPTH]; // {dev, word}
   logic [PTR_W-1:0]   wr_ptr;
   logic [PTR_W-1:0]   rd_ptr;
   logic [PTR_W:0]     count;
   logic [2:0]         push_dev;
   logic               push;
   logic               pop;

   // one-hot select back to a device number
   always_comb begin
      push_dev = '0;
      for (int i = 0; i < `DEV_COUNT; i++) begin
         if (oreg_wen[i]) begin
            push_dev = 3'(i);
         end
      end
   end

   assign push = |oreg_wen;
   assign pop  = cmd_pop & (count != '0);

   always_ff @(posedge clock) begin
      if (push) begin
         fifo[wr_ptr] <= {push_dev, oreg};
      end
   end

   always_ff @(posedge clock) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1; // wraps at depth
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   assign {cmd_dev, cmd_word} = fifo[rd_ptr];
   assign cmd_valid = (count != '0);
   assign empty     = (count == '0);

   // early full, room left for one registered and one in-flight command
   assign hold = (count >= (PTR_W + 1)'(`CMD_DEPTH - 2));

endmodule

// ==== verilog/dev_bank.sv ====
`timescale 1ns/1ps
`include "seq_consts.svh"

module dev_bank (
   input  logic                    clock,
   input  logic                    reset,
   input  logic                    cmd_valid,
   input  logic [2:0]              cmd_dev,
   input  logic [`SEQ_CMD_W-1:0]   cmd_word,
   input  logic                    empty,
   output logic                    cmd_pop,
   output logic [`DEV_COUNT*8-1:0] dev_values,
   output logic                    idle
);

   logic [7:0] regs [`DEV_COUNT]; // single-port register array
   logic       busy;              // write phase of a command
   logic       swept;
   logic [2:0] sweep_ptr;
   logic [2:0] op_dev;
   logic [3:0] op_cmd;
   logic [7:0] op_arg;
   logic [7:0] op_data;           // register value read at pop
   logic [7:0] result;
   logic [2:0] mem_addr;
   logic       mem_we;
   logic [7:0] mem_wdata;
   logic [7:0] mem_rdata;

   // read phase: take the head entry whenever not writing
   assign cmd_pop = swept & ~busy & cmd_valid;
   assign idle    = swept & ~busy & empty;

   always_ff @(posedge clock) begin
      if (reset) begin
         busy      <= 1'b0;
         swept     <= 1'b0;
         sweep_ptr <= '0;
      end else begin
         if (!swept) begin
            sweep_ptr <= sweep_ptr + 1'b1;
            if (&sweep_ptr) begin
               swept <= 1'b1; // last register cleared
            end
         end
         busy <= cmd_pop; // every pop is followed by exactly one write
      end
   end

   always_ff @(posedge clock) begin
      if (cmd_pop) begin
         op_dev  <= cmd_dev;
         op_cmd  <= cmd_word[11:8];
         op_arg  <= cmd_word[7:0];
         op_data <= mem_rdata;
      end
   end

   always_comb begin
      case (op_cmd)
         `DEV_OP_LOAD:  result = op_arg;
         `DEV_OP_ADD:   result = op_data + op_arg; // wraps at 8 bits
         `DEV_OP_XOR:   result = op_data ^ op_arg;
         `DEV_OP_CLEAR: result = 8'h00;
         default:       result = op_data;          // unknown, value kept
      endcase
   end

   // one address per cycle: sweep, write back, or read for a pop
   always_comb begin
      mem_addr  = cmd_dev;
      mem_we    = 1'b0;
      mem_wdata = result;
      if (!swept) begin
         mem_addr  = sweep_ptr;
         mem_we    = 1'b1;
         mem_wdata = 8'h00;
      end else if (busy) begin
         mem_addr = op_dev;
         mem_we   = 1'b1;
      end
   end

   assign mem_rdata = regs[mem_addr];

   always_ff @(posedge clock) begin
      if (mem_we) begin
         regs[mem_addr] <= mem_wdata;
      end
   end

   // flattened view, zero until the sweep is done
   always_comb begin
      for (int i = 0; i < `DEV_COUNT; i++) begin
         dev_values[i*8 +: 8] = swept ? regs[i] : 8'h00;
      end
   end

endmodule

// ==== verilog/seq_consts.svh ====
`ifndef SEQ_CONSTS_SVH
`define SEQ_CONSTS_SVH

// sequencer opcodes, top nibble of every instruction
`define SEQ_OP_NO 4'h0
`define SEQ_OP_CI 4'h1
`define SEQ_OP_CR 4'h2
`define SEQ_OP_JI 4'h3
`define SEQ_OP_JR 4'h4
`define SEQ_OP_JZ 4'h5
`define SEQ_OP_JN 4'h6

// core FSM states
`define SEQ_ST_RESET 2'h0
`define SEQ_ST_READY 2'h1
`define SEQ_ST_ERROR 2'h2

`define SEQ_INST_W 20 // instruction word
`define SEQ_ADDR_W 8  // program address
`define SEQ_CMD_W  12 // device command (4) + argument (8)

`define DEV_COUNT 8
`define CMD_DEPTH 8   // power of two, at least 4

// device command values
`define DEV_OP_LOAD  4'h0
`define DEV_OP_ADD   4'h1
`define DEV_OP_XOR   4'h2
`define DEV_OP_CLEAR 4'h3

`endif

// ==== verilog/seq_core.sv ====
`timescale 1ns/1ps
`include "seq_consts.svh"

module seq_core (
   input  logic                   clock,
   input  logic                   reset,
   input  seq_pkg::seq_inst_t     inst,
   input  logic                   inst_en,
   input  logic [7:0]             ireg_0,
   input  logic [7:0]             ireg_1,
   input  logic [7:0]             ireg_2,
   input  logic [7:0]             ireg_3,
   output logic [`SEQ_ADDR_W-1:0] next,
   output logic                   running,
   output logic                   error,
   output logic [`SEQ_CMD_W-1:0]  oreg,
   output logic [`DEV_COUNT-1:0]  oreg_wen
);

   logic [1:0]             state;
   logic [3:0]             opcode;
   logic [7:0]             label;
   logic [7:0]             src_val;
   logic [`DEV_COUNT-1:0]  dev_sel;
   logic [`SEQ_ADDR_W-1:0] next_seq;

   assign opcode   = inst.cmd_view.opcode; // same position in both views
   assign label    = inst.jump_view.label;
   assign next_seq = next + 1'b1;

   // 3-to-8 device select
   assign dev_sel = `DEV_COUNT'(1) << inst.cmd_view.dev;

   always_comb begin
      case (inst.jump_view.src)
         2'd0:    src_val = ireg_0;
         2'd1:    src_val = ireg_1;
         2'd2:    src_val = ireg_2;
         default: src_val = ireg_3;
      endcase
   end

   assign running = (state == `SEQ_ST_READY);
   assign error   = (state == `SEQ_ST_ERROR);

   always_ff @(posedge clock) begin
      if (reset) begin
         state    <= `SEQ_ST_RESET;
         next     <= '0;
         oreg     <= '0;
         oreg_wen <= '0;
      end else begin
         oreg_wen <= '0; // strobe lasts one cycle
         case (state)
            `SEQ_ST_RESET: begin
               state <= `SEQ_ST_READY;
               next  <= '0;
            end

            `SEQ_ST_READY: begin
               // without inst_en the address just holds
               if (inst_en) begin
                  case (opcode)
                     `SEQ_OP_NO: begin
                        next <= next_seq;
                     end
                     `SEQ_OP_CI: begin
                        next     <= next_seq;
                        oreg     <= {inst.cmd_view.dev_cmd, inst.cmd_view.arg};
                        oreg_wen <= dev_sel;
                     end
                     `SEQ_OP_CR: begin
                        next     <= next_seq;
                        oreg     <= {inst.cmd_view.dev_cmd, src_val};
                        oreg_wen <= dev_sel;
                     end
                     `SEQ_OP_JI: begin
                        next <= label;
                     end
                     `SEQ_OP_JR: begin
                        next <= src_val; // computed jump
                     end
                     `SEQ_OP_JZ: begin
                        next <= (src_val == 8'h00) ? label : next_seq;
                     end
                     `SEQ_OP_JN: begin
                        next <= (src_val != 8'h00) ? label : next_seq;
                     end
                     default: begin
                        // illegal opcode, stuck until reset
                        state <= `SEQ_ST_ERROR;
                        next  <= '0;
                     end
                  endcase
               end
            end

            `SEQ_ST_ERROR: begin
               next <= '0;
            end

            default: begin
               state <= `SEQ_ST_ERROR;
               next  <= '0;
            end
         endcase
      end
   end

endmodule

// ==== verilog/seq_pkg.sv ====
package seq_pkg;

   // command form: ci / cr
   typedef struct packed {
      logic [3:0] opcode;
      logic       pad;
      logic [2:0] dev;
      logic [3:0] dev_cmd;
      logic [7:0] arg;     // immediate for ci
   } seq_cmd_view_t;

   // jump form: ji / jr / jz / jn, also gives src for cr
   typedef struct packed {
      logic [3:0] opcode;
      logic [7:0] label;
      logic [5:0] unused;
      logic [1:0] src;     // input register select
   } seq_jump_view_t;

   // same 20 bits, decoded either way
   typedef union packed {
      seq_cmd_view_t  cmd_view;
      seq_jump_view_t jump_view;
   } seq_inst_t;

endpackage

// ==== verilog/seq_prog_mem.sv ====
`timescale 1ns/1ps
`include "seq_consts.svh"

module seq_prog_mem (
   input  logic                   clock,
   input  logic                   prog_wen,
   input  logic [`SEQ_ADDR_W-1:0] prog_addr,
   input  seq_pkg::seq_inst_t     prog_data,
   input  logic [`SEQ_ADDR_W-1:0] next,
   input  logic                   hold,
   input  logic                   running,
   output seq_pkg::seq_inst_t     inst,
   output logic                   inst_en
);

   localparam int DEPTH = 1 << `SEQ_ADDR_W;

   logic [`SEQ_INST_W-1:0] mem [DEPTH];

   // load port, only used while the system sits in reset
   always_ff @(posedge clock) begin
      if (prog_wen) begin
         mem[prog_addr] <= prog_data;
      end
   end

   assign inst = mem[next]; // async read at the core's address

   // nothing presented unless the core is ready and the buffer has room
   assign inst_en = running & ~hold;

endmodule

// ==== verilog/seq_soc.sv ====
`timescale 1ns/1ps
`include "seq_consts.svh"

module seq_soc (
   input  logic                    clock,
   input  logic                    reset,
   input  logic                    prog_wen,
   input  logic [`SEQ_ADDR_W-1:0]  prog_addr,
   input  seq_pkg::seq_inst_t      prog_data,
   input  logic [7:0]              ireg_0,
   input  logic [7:0]              ireg_1,
   input  logic [7:0]              ireg_2,
   input  logic [7:0]              ireg_3,
   output logic [`SEQ_ADDR_W-1:0]  next,
   output logic                    error,
   output logic [`DEV_COUNT*8-1:0] dev_values,
   output logic                    idle
);

   import seq_pkg::*;

   seq_inst_t             inst;
   logic                  inst_en;
   logic                  running;
   logic                  hold;
   logic [`SEQ_CMD_W-1:0] oreg;
   logic [`DEV_COUNT-1:0] oreg_wen;
   logic                  cmd_valid;
   logic                  cmd_pop;
   logic [2:0]            cmd_dev;
   logic [`SEQ_CMD_W-1:0] cmd_word;
   logic                  empty;

   seq_prog_mem seq_prog_mem_inst (
      .clock     (clock),
      .prog_wen  (prog_wen),
      .prog_addr (prog_addr),
      .prog_data (prog_data),
      .next      (next),
      .hold      (hold),
      .running   (running),
      .inst      (inst),
      .inst_en   (inst_en)
   );

   seq_core seq_core_inst (
      .clock    (clock),
      .reset    (reset),
      .inst     (inst),
      .inst_en  (inst_en),
      .ireg_0   (ireg_0),
      .ireg_1   (ireg_1),
      .ireg_2   (ireg_2),
      .ireg_3   (ireg_3),
      .next     (next),
      .running  (running),
      .error    (error),
      .oreg     (oreg),
      .oreg_wen (oreg_wen)
   );

   // absorbs bursts, the device bank drains at most every other cycle
   cmd_buffer cmd_buffer_inst (
      .clock     (clock),
      .reset     (reset),
      .oreg      (oreg),
      .oreg_wen  (oreg_wen),
      .cmd_pop   (cmd_pop),
      .cmd_valid (cmd_valid),
      .cmd_dev   (cmd_dev),
      .cmd_word  (cmd_word),
      .hold      (hold),
      .empty     (empty)
   );

   dev_bank dev_bank_inst (
      .clock      (clock),
      .reset      (reset),
      .cmd_valid  (cmd_valid),
      .cmd_dev    (cmd_dev),
      .cmd_word   (cmd_word),
      .empty      (empty),
      .cmd_pop    (cmd_pop),
      .dev_values (dev_values),
      .idle       (idle)
   );

endmodule
